/* vlog.f */
logic/spi_bridge_pkg.sv
logic/spi_shifter.sv
logic/sync2_edge_detect.sv
logic/spi1_controller.sv
logic/ram_bank.sv
logic/bank_ack_collect.sv
logic/spi_mem_top.sv
testbench/tb_clock_gen.sv
testbench/spi_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the SPI memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module spi_mem_tb -o spi_mem_sim \
    || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/spi_mem_sim)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* testbench/spi_mem_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI memory bridge testbench
// Bit-bangs MCU commands, keeps a byte model of the
// 128 KB memory and checks every returned byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spi_mem_tb;

    localparam int unsigned SEED       = 32'he81d_9283;
    localparam int          MEM_BYTES  = 2**spi_bridge_pkg::ADDR_WIDTH;
    localparam int          NUM_RANDOM = 200;
    localparam int          RUN_LEN    = 4;    // Increment run across the bank 1/2 edge
    localparam int          NUM_OPS    = 2 + 2*RUN_LEN + NUM_RANDOM + 3;
    localparam int          TIMEOUT_NS = NUM_OPS * 4 * 8 * 8 * 20 + 50_000;
    localparam int          STALL_WAIT = 64;   // Clocks allowed for a stall edge
    localparam int          CS_GAP     = 8;    // Deselect time, longer than the 3 clock sync

    logic clock;
    logic rst;
    logic spi_cs_n;
    logic spi_sclk;
    logic spi_sd_in;
    logic spi_sd_out;
    logic spi_stall;

    logic [7:0]  model_mem   [MEM_BYTES];   // Expected memory image
    bit          model_known [MEM_BYTES];   // Written since reset
    logic [16:0] model_addr;                // Follows the increment rule
    logic [7:0]  exp_byte;                  // Due in the next transaction's first byte
    logic [16:0] exp_addr;
    bit          exp_known;
    logic [16:0] pool [8];                  // Hot spots so random reads hit written bytes
    int          value_errors;
    int          other_errors;
    int          bytes_checked;

    tb_clock_gen u_clock_gen (
        .clock_o(clock),
        .reset_o(rst)
    );

    spi_mem_top spi_mem_top_inst (
        .clock_i    (clock),
        .spi_sck_i  (rst),
        .spi_cs_ni  (spi_cs_n),
        .spi_sclk_i (spi_sclk),
        .spi_sd_i   (spi_sd_in),
        .spi_sd_o   (spi_sd_out),
        .spi_stall_o(spi_stall)
    );

    // Polls stall once per clock, gives up after STALL_WAIT clocks
    task automatic wait_stall(input logic level);
        int n;
        n = 0;
        while (spi_stall !== level && n < STALL_WAIT) begin
            @(posedge clock);
            n++;
        end
        assert (spi_stall === level) else begin
            other_errors++;
            $display("Stall line never went to %0b within %0d clocks, at %0t ns",
                     level, STALL_WAIT, $time);
        end
    endtask

    // Mode 0, MSB first, 8 clocks per bit
    task automatic shift_byte(input logic [7:0] mosi, input int nbits, output logic [7:0] miso);
        miso = '0;
        for (int i = 7; i >= 8 - nbits; i--) begin
            spi_sd_in <= mosi[i];              // Changes while SCLK is low
            repeat (4) @(posedge clock);
            miso[i] = spi_sd_out;              // Settled since the last falling edge
            spi_sclk <= 1'b1;
            repeat (4) @(posedge clock);
            spi_sclk <= 1'b0;
        end
    endtask

    // One chip select window, abort_bits > 0 cuts the last byte short
    task automatic transfer(input logic [7:0] tx [4], input int count, input int abort_bits);
        logic [7:0] rx [4];
        int         nbits;
        wait_stall(1'b0);                      // MCU may only start when not stalled
        spi_cs_n <= 1'b0;
        for (int b = 0; b < count; b++) begin
            nbits = (b == count - 1 && abort_bits > 0) ? abort_bits : 8;
            shift_byte(tx[b], nbits, rx[b]);
        end
        if (abort_bits > 0) begin
            @(posedge clock);
            spi_cs_n <= 1'b1;
            repeat (CS_GAP) @(posedge clock);
            assert (spi_stall == 1'b0) else begin
                value_errors++;
                $display("ERROR %0t ns: stall still high after an aborted command", $time);
            end
        end else begin
            wait_stall(1'b1);
            wait_stall(1'b0);                  // Bus cycle acknowledged
            spi_cs_n <= 1'b1;
            repeat (CS_GAP) @(posedge clock);
        end
        if (exp_known) begin
            bytes_checked++;
            assert (rx[0] == exp_byte) else begin
                value_errors++;
                $display("ERROR %0t ns: returned %02h for address %05h, expected %02h",
                         $time, rx[0], exp_addr, exp_byte);
            end
        end
    endtask

    // Builds the byte frame, runs it and advances the model
    task automatic run_command(input bit we, input bit set_addr, input logic [16:0] addr,
                               input logic [7:0] data, input int abort_bits);
        logic [7:0] frame [4];
        int         count;
        frame[0] = '0;
        frame[0][spi_bridge_pkg::CMD_WE_BIT]       = we;
        frame[0][spi_bridge_pkg::CMD_SET_ADDR_BIT] = set_addr;
        if (set_addr) begin
            frame[0][spi_bridge_pkg::CMD_A16_BIT] = addr[16];
        end
        count = 1;
        if (we) begin
            frame[count] = data;               // Data precedes the address bytes
            count++;
        end
        if (set_addr) begin
            frame[count]     = addr[15:8];
            frame[count + 1] = addr[7:0];
            count += 2;
        end
        if (abort_bits > 0) begin
            count = 2;                         // Cut inside the data byte
        end
        transfer(frame, count, abort_bits);
        if (abort_bits > 0) begin
            // Command byte was decoded, so only its address effect remains
            if (set_addr) begin
                model_addr[16] = addr[16];
            end else begin
                model_addr = model_addr + 17'd1;
            end
        end else begin
            model_addr = set_addr ? addr : model_addr + 17'd1;
            exp_addr   = model_addr;
            exp_byte   = model_mem[model_addr];    // Old contents, also for a write
            exp_known  = model_known[model_addr];
            if (we) begin
                model_mem[model_addr]   = data;
                model_known[model_addr] = 1'b1;
            end
        end
    endtask

    initial begin
        logic [16:0] addr;
        logic [16:0] probe_addr;
        logic [7:0]  data;
        bit          we;
        bit          set_addr;
        value_errors  = 0;
        other_errors  = 0;
        bytes_checked = 0;
        exp_known     = 1'b0;
        model_addr    = '0;
        void'($urandom(SEED));
        spi_cs_n  <= 1'b1;
        spi_sclk  <= 1'b0;
        spi_sd_in <= 1'b0;
        @(posedge clock);
        while (rst) @(posedge clock);

        // Idle after reset, chip select high
        repeat (20) begin
            @(posedge clock);
            assert (spi_stall == 1'b0) else begin
                value_errors++;
                $display("ERROR %0t ns: stall high while deselected", $time);
            end
        end

        // Write then read back one random address
        probe_addr = 17'($urandom);
        run_command(1'b1, 1'b1, probe_addr, 8'($urandom), 0);
        run_command(1'b0, 1'b1, probe_addr, 8'h00, 0);

        // Bank 1 offset 7FFE, the run crosses into bank 2
        for (int i = 0; i < RUN_LEN; i++) begin
            run_command(1'b1, i == 0, {2'd1, 15'h7FFE}, 8'($urandom), 0);
        end
        for (int i = 0; i < RUN_LEN; i++) begin
            run_command(1'b0, i == 0, {2'd1, 15'h7FFE}, 8'h00, 0);
        end

        // Random mix of directions and addressing
        for (int i = 0; i < 8; i++) begin
            pool[i] = 17'($urandom);
        end
        for (int i = 0; i < NUM_RANDOM; i++) begin
            we       = 1'($urandom);
            set_addr = ($urandom % 3) == 0;
            addr     = pool[3'($urandom)] + 17'($urandom % 16);
            data     = 8'($urandom);
            run_command(we, set_addr, addr, data, 0);
        end

        // Write aborted inside its data byte must leave memory alone
        run_command(1'b1, 1'b1, probe_addr, ~model_mem[probe_addr], 4);
        run_command(1'b0, 1'b1, probe_addr, 8'h00, 0);
        run_command(1'b0, 1'b0, 17'h0, 8'h00, 0);    // Collects the last read byte

        $display("Done: %0d bytes compared, %0d value errors, %0d other errors",
                 bytes_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog, sized for four full bytes per command plus margin
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source
// 20 ns bus clock, reset held for the first 16 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock_o,   // 50 MHz bus clock
    output logic reset_o    // Active high
);

    initial begin
        clock_o = 1'b0;
        reset_o = 1'b1;
        forever #10 clock_o = ~clock_o;
    end

    initial begin
        repeat (16) @(posedge clock_o);
        reset_o <= 1'b0;    // Released on a rising edge
    end

endmodule

/* logic/spi_mem_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI accessible 128 KB memory, top level
// Controller, four RAM banks and the ack collector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spi_mem_top (
    input  logic clock_i,      // Bus clock
    input  logic spi_sck_i,    // Async reset, active high
    input  logic spi_cs_ni,
    input  logic spi_sclk_i,   // SPI serial clock, mode 0
    input  logic spi_sd_i,
    output logic spi_sd_o,
    output logic spi_stall_o
);

    spi_bridge_pkg::bus_addr_u             bus_addr;     // Broadcast to every bank
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_wdata;
    logic                                  bus_we;
    logic                                  bus_cycle;
    logic                                  bus_ack;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_rdata;
    logic [spi_bridge_pkg::NUM_BANKS-1:0]  bank_ack;
    logic [spi_bridge_pkg::NUM_BANKS-1:0]
          [spi_bridge_pkg::DATA_WIDTH-1:0] bank_rdata;

    spi1_controller u_ctrl (
        .clock_i    (clock_i),
        .spi_sck_i  (spi_sck_i),
        .spi_cs_ni  (spi_cs_ni),
        .spi_sclk_i (spi_sclk_i),
        .spi_sd_i   (spi_sd_i),
        .spi_sd_o   (spi_sd_o),
        .spi_stall_o(spi_stall_o),
        .bus_addr_o (bus_addr),
        .bus_wdata_o(bus_wdata),
        .bus_we_o   (bus_we),
        .bus_cycle_o(bus_cycle),
        .bus_rdata_i(bus_rdata),
        .bus_ack_i  (bus_ack)
    );

    for (genvar g = 0; g < spi_bridge_pkg::NUM_BANKS; g++) begin : g_bank
        ram_bank #(
            .BANK_INDEX(g)
        ) u_bank (
            .clock_i    (clock_i),
            .spi_sck_i  (spi_sck_i),
            .bus_addr_i (bus_addr),
            .bus_wdata_i(bus_wdata),
            .bus_we_i   (bus_we),
            .bus_cycle_i(bus_cycle),
            .ack_o      (bank_ack[g]),
            .rdata_o    (bank_rdata[g])
        );
    end

    bank_ack_collect u_collect (
        .clock_i     (clock_i),
        .spi_sck_i   (spi_sck_i),
        .bank_ack_i  (bank_ack),
        .bank_rdata_i(bank_rdata),
        .bus_ack_o   (bus_ack),
        .bus_rdata_o (bus_rdata)
    );

endmodule

/* logic/bank_ack_collect.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bank acknowledge collector
// Returns the answering bank's ack and read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bank_ack_collect (
    input  logic                                  clock_i,
    input  logic                                  spi_sck_i,    // Async reset, active high
    input  logic [spi_bridge_pkg::NUM_BANKS-1:0]  bank_ack_i,
    input  logic [spi_bridge_pkg::NUM_BANKS-1:0]
                 [spi_bridge_pkg::DATA_WIDTH-1:0] bank_rdata_i,
    output logic                                  bus_ack_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_rdata_o   // Valid with bus_ack_o
);

    logic [spi_bridge_pkg::DATA_WIDTH-1:0] sel_data;

    // AND-OR mux, only the acking bank contributes
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < spi_bridge_pkg::NUM_BANKS; i++) begin
            if (bank_ack_i[i]) begin
                sel_data |= bank_rdata_i[i];
            end
        end
    end

    always_ff @(posedge clock_i or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bus_ack_o <= 1'b0;
        end else begin
            bus_ack_o <= |bank_ack_i;
        end
    end

    always_ff @(posedge clock_i) begin
        bus_rdata_o <= sel_data;
    end

    a_one_bank: assert property (@(posedge clock_i) disable iff (spi_sck_i)
        $onehot0(bank_ack_i))
        else $error("more than one bank answered a bus cycle");

endmodule

/* logic/ram_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 KB byte wide memory bank
// Answers bus cycles whose bank field matches its index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ram_bank #(
    parameter int unsigned BANK_INDEX = 0   // 0 .. NUM_BANKS-1
) (
    input  logic                                  clock_i,
    input  logic                                  spi_sck_i,   // Async reset, active high
    input  spi_bridge_pkg::bus_addr_u             bus_addr_i,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_wdata_i,
    input  logic                                  bus_we_i,
    input  logic                                  bus_cycle_i,
    output logic                                  ack_o,       // One clock per cycle
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] rdata_o      // Contents before any write
);

    logic [spi_bridge_pkg::DATA_WIDTH-1:0] mem [2**spi_bridge_pkg::OFFSET_BITS];
    logic                                  done;   // Already answered this cycle
    logic                                  hit;

    assign hit = bus_cycle_i && !done &&
                 (bus_addr_i.split.bank == spi_bridge_pkg::BANK_BITS'(BANK_INDEX));

    always_ff @(posedge clock_i or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            ack_o <= 1'b0;
            done  <= 1'b0;
        end else begin
            ack_o <= hit;
            done  <= bus_cycle_i && (done || hit);  // Rearm once the cycle drops
        end
    end

    // Read old data and write on the same answering clock
    always_ff @(posedge clock_i) begin
        if (hit) begin
            rdata_o <= mem[bus_addr_i.split.offset];
            if (bus_we_i) begin
                mem[bus_addr_i.split.offset] <= bus_wdata_i;
            end
        end
    end

    a_ack_in_cycle: assert property (@(posedge clock_i) disable iff (spi_sck_i)
        ack_o |-> bus_cycle_i)
        else $error("bank %0d acknowledged outside a bus cycle", BANK_INDEX);

endmodule

/* logic/spi1_controller.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI command decoder and bus master
// Decodes MCU commands on SCLK, runs the bus cycle on
// clock_i and stalls the MCU until it completes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spi1_controller (
    input  logic                                  clock_i,      // Bus clock
    input  logic                                  spi_sck_i,    // Async reset, active high
    input  logic                                  spi_cs_ni,
    input  logic                                  spi_sclk_i,
    input  logic                                  spi_sd_i,
    output logic                                  spi_sd_o,
    output logic                                  spi_stall_o,  // MCU must wait while high
    output spi_bridge_pkg::bus_addr_u             bus_addr_o,
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_wdata_o,
    output logic                                  bus_we_o,     // 1 = write
    output logic                                  bus_cycle_o,
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] bus_rdata_i,  // Valid with bus_ack_i
    input  logic                                  bus_ack_i
);

    // SCLK side states where only VALID sets bit 2
    localparam logic [2:0] ST_CMD     = 3'b000;
    localparam logic [2:0] ST_DATA    = 3'b001;
    localparam logic [2:0] ST_ADDR_HI = 3'b010;
    localparam logic [2:0] ST_ADDR_LO = 3'b011;
    localparam logic [2:0] ST_VALID   = 3'b100;

    // Bus side states with stall in bit 0 and cycle in bit 1
    localparam logic [1:0] BS_READY      = 2'b00;
    localparam logic [1:0] BS_RECEIVING  = 2'b01;
    localparam logic [1:0] BS_PROCESSING = 2'b11;

    logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_byte;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] tx_byte;   // Read result for next transaction
    logic                                  byte_strobe;
    logic [2:0]                            sck_state;
    logic                                  sck_rst;    // Global reset or deselect
    logic                                  set_addr;   // Current command carries an address
    logic [1:0]                            bus_state;
    logic                                  cs_fall;
    logic                                  cs_rise;
    logic                                  valid_rise;

    spi_shifter u_shifter (
        .spi_cs_ni    (spi_cs_ni),
        .spi_sclk_i   (spi_sclk_i),
        .spi_sd_i     (spi_sd_i),
        .spi_sd_o     (spi_sd_o),
        .tx_byte_i    (tx_byte),
        .rx_byte_o    (rx_byte),
        .byte_strobe_o(byte_strobe)
    );

    assign sck_rst = spi_sck_i | spi_cs_ni;

    // Command FSM decoding on the falling edge that closes each byte
    always_ff @(negedge spi_sclk_i or posedge sck_rst) begin
        if (sck_rst) begin
            sck_state <= ST_CMD;
        end else if (byte_strobe) begin
            case (sck_state)
                ST_CMD: begin
                    if (rx_byte[spi_bridge_pkg::CMD_WE_BIT]) begin
                        sck_state <= ST_DATA;              // Data byte comes first
                    end else if (rx_byte[spi_bridge_pkg::CMD_SET_ADDR_BIT]) begin
                        sck_state <= ST_ADDR_HI;
                    end else begin
                        sck_state <= ST_VALID;             // Increment read is one byte
                    end
                end
                ST_DATA:    sck_state <= set_addr ? ST_ADDR_HI : ST_VALID;
                ST_ADDR_HI: sck_state <= ST_ADDR_LO;
                ST_ADDR_LO: sck_state <= ST_VALID;
                default:    sck_state <= ST_VALID;         // Hold until deselected
            endcase
        end
    end

    // Address and direction survive between transactions for the increment
    always_ff @(negedge spi_sclk_i or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bus_addr_o <= '0;
            bus_we_o   <= 1'b0;
            set_addr   <= 1'b0;
        end else if (byte_strobe) begin
            if (sck_state == ST_CMD) begin
                bus_we_o <= rx_byte[spi_bridge_pkg::CMD_WE_BIT];
                set_addr <= rx_byte[spi_bridge_pkg::CMD_SET_ADDR_BIT];
                if (rx_byte[spi_bridge_pkg::CMD_SET_ADDR_BIT]) begin
                    bus_addr_o.flat[spi_bridge_pkg::ADDR_WIDTH-1] <=
                        rx_byte[spi_bridge_pkg::CMD_A16_BIT];   // A16 rides in the command
                end else begin
                    bus_addr_o.flat <= bus_addr_o.flat + 1'b1;
                end
            end else if (sck_state == ST_ADDR_HI) begin
                bus_addr_o.flat[15:8] <= rx_byte;
            end else if (sck_state == ST_ADDR_LO) begin
                bus_addr_o.flat[7:0] <= rx_byte;
            end
        end
    end

    always_ff @(negedge spi_sclk_i) begin
        if (byte_strobe && sck_state == ST_DATA) begin
            bus_wdata_o <= rx_byte;
        end
    end

    sync2_edge_detect u_sync_cs (
        .clock_i  (clock_i),
        .spi_sck_i(spi_sck_i),
        .data_i   (spi_cs_ni),
        .pe_o     (cs_rise),      // Deselect
        .ne_o     (cs_fall)       // Select
    );

    sync2_edge_detect u_sync_valid (
        .clock_i  (clock_i),
        .spi_sck_i(spi_sck_i),
        .data_i   (sck_state[2]), // High only in ST_VALID
        .pe_o     (valid_rise),
        .ne_o     ()
    );

    // Bus cycle FSM
    always_ff @(posedge clock_i or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            bus_state <= BS_READY;
        end else if (cs_rise) begin
            bus_state <= BS_READY;                   // Deselect aborts anything pending
        end else begin
            case (bus_state)
                BS_READY:      if (cs_fall)    bus_state <= BS_RECEIVING;
                BS_RECEIVING:  if (valid_rise) bus_state <= BS_PROCESSING;
                BS_PROCESSING: if (bus_ack_i)  bus_state <= BS_READY;
                default:       bus_state <= BS_READY;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (bus_state == BS_PROCESSING && bus_ack_i) begin
            tx_byte <= bus_rdata_i;   // Shifted out in the next transaction
        end
    end

    assign spi_stall_o = bus_state[0];
    assign bus_cycle_o = bus_state[1];

    // Bank answer plus collector register give exactly two clocks to the ack
    a_ack_two_clocks: assert property (@(posedge clock_i) disable iff (spi_sck_i)
        $past(bus_cycle_o, 2) && !$past(bus_cycle_o, 3) |-> bus_ack_i)
        else $error("bus cycle not acknowledged two clocks after it started");

endmodule

/* logic/sync2_edge_detect.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two flop synchronizer with edge pulses
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sync2_edge_detect (
    input  logic clock_i,
    input  logic spi_sck_i,   // Async reset, active high
    input  logic data_i,      // Level from another clock domain
    output logic pe_o,        // One clock pulse on rising edge
    output logic ne_o         // One clock pulse on falling edge
);

    logic meta;      // First stage, may go metastable
    logic synced;
    logic history;   // synced one clock ago

    // Idle high matches a deselected chip select
    always_ff @(posedge clock_i or posedge spi_sck_i) begin
        if (spi_sck_i) begin
            meta    <= 1'b1;
            synced  <= 1'b1;
            history <= 1'b1;
        end else begin
            meta    <= data_i;
            synced  <= meta;
            history <= synced;
        end
    end

    assign pe_o = synced & ~history;
    assign ne_o = ~synced & history;

endmodule

/* logic/spi_shifter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI mode 0 byte shifter, serial clock domain
// Receives bytes MSB first and strobes each full byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module spi_shifter (
    input  logic                                  spi_cs_ni,     // Chip select, active low
    input  logic                                  spi_sclk_i,    // Serial clock
    input  logic                                  spi_sd_i,      // MCU to FPGA
    output logic                                  spi_sd_o,      // FPGA to MCU
    input  logic [spi_bridge_pkg::DATA_WIDTH-1:0] tx_byte_i,     // Next byte to send
    output logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_byte_o,     // Last byte received
    output logic                                  byte_strobe_o  // rx_byte_o complete
);

    logic [2:0]                            bit_cnt;     // Bits seen in current byte
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] rx_shift;
    logic [spi_bridge_pkg::DATA_WIDTH-1:0] tx_shift;
    logic                                  tx_loaded;   // tx_shift owns spi_sd_o

    // Bit counter and strobe, cleared whenever the MCU deselects us
    always_ff @(posedge spi_sclk_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            bit_cnt       <= '0;
            byte_strobe_o <= 1'b0;
        end else begin
            bit_cnt       <= bit_cnt + 1'b1;
            byte_strobe_o <= (bit_cnt == 3'd7);   // High for one SCLK period after bit 8
        end
    end

    always_ff @(posedge spi_sclk_i) begin
        rx_shift <= {rx_shift[spi_bridge_pkg::DATA_WIDTH-2:0], spi_sd_i};  // MSB first
    end

    assign rx_byte_o = rx_shift;

    // First bit of a transaction comes straight from tx_byte_i,
    // the shift register takes over on the first falling edge
    always_ff @(negedge spi_sclk_i or posedge spi_cs_ni) begin
        if (spi_cs_ni) begin
            tx_loaded <= 1'b0;
        end else begin
            tx_loaded <= 1'b1;
        end
    end

    always_ff @(negedge spi_sclk_i) begin
        if (byte_strobe_o) begin
            tx_shift <= tx_byte_i;                 // Reload between bytes
        end else if (!tx_loaded) begin
            tx_shift <= {tx_byte_i[spi_bridge_pkg::DATA_WIDTH-2:0], 1'b0};  // MSB already sent
        end else begin
            tx_shift <= {tx_shift[spi_bridge_pkg::DATA_WIDTH-2:0], 1'b0};
        end
    end

    assign spi_sd_o = tx_loaded ? tx_shift[spi_bridge_pkg::DATA_WIDTH-1]
                                : tx_byte_i[spi_bridge_pkg::DATA_WIDTH-1];

endmodule

/* logic/spi_bridge_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SPI memory bridge shared definitions
// Bus widths, bank layout, command byte bits and the
// bus address view used by controller and banks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package spi_bridge_pkg;

    // Bus geometry
    localparam int DATA_WIDTH  = 8;    // One byte per bus cycle
    localparam int ADDR_WIDTH  = 17;   // 128 KB total
    localparam int NUM_BANKS   = 4;
    localparam int BANK_BITS   = 2;    // log2 of NUM_BANKS
    localparam int OFFSET_BITS = 15;   // 32 KB per bank

    // Command byte layout
    localparam int CMD_WE_BIT       = 7;  // 1 = write, 0 = read
    localparam int CMD_SET_ADDR_BIT = 6;  // 1 = address bytes follow, 0 = increment
    localparam int CMD_A16_BIT      = 0;  // Address bit 16 on a set-address command

    // Bus address, seen either as one number or as bank over offset
    typedef union packed {
        logic [ADDR_WIDTH-1:0] flat;              // Used for the auto increment
        struct packed {
            logic [BANK_BITS-1:0]   bank;         // Selects one ram_bank
            logic [OFFSET_BITS-1:0] offset;       // Index inside that bank
        } split;
    } bus_addr_u;

endpackage
